// ==== Bender.yml ====
package:
  name: rv_mini

sources:
  # shared definitions first
  - src/rv_mini_pkg.sv
  - src/rv_mini_regfile.sv
  - src/rv_mini_core.sv
  - src/rv_mini_mem_arbiter.sv
  - src/rv_mini_sram.sv
  - src/rv_mini_top.sv

  - target: test
    files:
      - verif/tb_rv_mini.sv

// ==== rv_mini.f ====
src/rv_mini_pkg.sv
src/rv_mini_regfile.sv
src/rv_mini_core.sv
src/rv_mini_mem_arbiter.sv
src/rv_mini_sram.sv
src/rv_mini_top.sv
verif/tb_rv_mini.sv

// ==== verif/rv_mini_tests.txt ====
# test <name> | load <word addr> <word> | run <expected trap>
# expect <word addr> <word>; numbers in hex, addresses are word addresses
test doubler
load 000 00100093  # addi x1, x0, 1
load 001 00500113  # addi x2, x0, 5
load 002 001080b3  # add  x1, x1, x1
load 003 fff10113  # addi x2, x2, -1
load 004 fe011ce3  # bne  x2, x0, -8
load 005 40102023  # sw   x1, 0x400(x0)
load 006 00100073  # ebreak
load 100 00000000
run 0
expect 100 00000020
test fibonacci
load 000 00000093  # addi x1, x0, 0
load 001 00100113  # addi x2, x0, 1
load 002 00a00213  # addi x4, x0, 10
load 003 002081b3  # add  x3, x1, x2
load 004 000100b3  # add  x1, x2, x0
load 005 00018133  # add  x2, x3, x0
load 006 fff20213  # addi x4, x4, -1
load 007 fe0218e3  # bne  x4, x0, -16
load 008 44102023  # sw   x1, 0x440(x0)
load 009 44202223  # sw   x2, 0x444(x0)
load 00a 44302423  # sw   x3, 0x448(x0)
load 00b 00100073  # ebreak
run 0
expect 110 00000037
expect 111 00000059
expect 112 00000059
test load_store
load 000 48002083  # lw   x1, 0x480(x0)
load 001 48402103  # lw   x2, 0x484(x0)
load 002 002081b3  # add  x3, x1, x2
load 003 48302623  # sw   x3, 0x48c(x0)
load 004 00100073  # ebreak
load 120 12345678
load 121 f0f0f0f0
load 122 deadbeef
load 123 00000000
run 0
expect 123 03254768
expect 120 12345678
expect 121 f0f0f0f0
expect 122 deadbeef
test sub_lui
load 000 abcde0b7  # lui  x1, 0xabcde
load 001 00500113  # addi x2, x0, 5
load 002 00700193  # addi x3, x0, 7
load 003 40310233  # sub  x4, x2, x3
load 004 50102023  # sw   x1, 0x500(x0)
load 005 50402223  # sw   x4, 0x504(x0)
load 006 00100073  # ebreak
run 0
expect 140 abcde000
expect 141 fffffffe
test trap
load 000 05500093  # addi x1, x0, 0x55
load 001 54102023  # sw   x1, 0x540(x0)
load 002 0000000b  # custom-0 opcode, not supported
load 003 54102223  # sw   x1, 0x544(x0), never reached
load 004 00100073  # ebreak
load 150 00000000
load 151 cafef00d
run 1
expect 150 00000055
expect 151 cafef00d

// ==== verif/tb_rv_mini.sv ====
// rv_mini testbench
// bootload, run and check through the host port

`timescale 1ns/10ps

module tb_rv_mini;

    import rv_mini_pkg::*;

    localparam int    rand_seed    = 76727;
    localparam int    halt_timeout = 2000;
    localparam string tests_path   = "verif/rv_mini_tests.txt";

    logic              clk;
    logic              rst_n;
    logic              run;
    logic              host_en;
    logic              host_wr_en;
    logic [mem_aw-1:0] host_addr;
    logic [xlen-1:0]   host_wr_data;
    logic [xlen-1:0]   host_rd_data;
    logic              halted;
    logic              trap;

    int tests_run;
    int checks_done;

    rv_mini_top u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .host_en     (host_en),
        .host_wr_en  (host_wr_en),
        .host_addr   (host_addr),
        .host_wr_data(host_wr_data),
        .host_rd_data(host_rd_data),
        .halted      (halted),
        .trap        (trap)
    );

    // 10 ns clock
    always #5 clk = ~clk;

    // ----------------------------------------
    // reporting
    // ----------------------------------------
    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [xlen-1:0] actual,
                               input logic [xlen-1:0] expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("mismatch %s: got %h, expected %h",
                                        name, actual, expected));
        end
    endtask

    // ----------------------------------------
    // drivers entered 1 ns after a rising edge
    // ----------------------------------------
    task automatic reset_dut();
        rst_n        = 1'b0;
        run          = 1'b0;
        host_en      = 1'b0;
        host_wr_en   = 1'b0;
        host_addr    = '0;
        host_wr_data = '0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_value("halted", halted, 1'b0);
        check_value("trap", trap, 1'b0);
    endtask

    task automatic host_write(input logic [mem_aw-1:0] addr, input logic [xlen-1:0] data);
        int unsigned idle;
        host_en      = 1'b1;
        host_wr_en   = 1'b1;
        host_addr    = addr;
        host_wr_data = data;
        @(posedge clk);
        #1;
        host_en    = 1'b0;
        host_wr_en = 1'b0;
        // random gap between writes
        idle = $urandom_range(3, 0);
        repeat (idle) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic host_read(input logic [mem_aw-1:0] addr, output logic [xlen-1:0] data);
        host_en    = 1'b1;
        host_wr_en = 1'b0;
        host_addr  = addr;
        @(posedge clk);
        #1;
        host_en = 1'b0;
        // sram output registered on that edge
        data = host_rd_data;
    endtask

    task automatic run_to_halt(input logic exp_trap);
        int cycles;
        cycles = 0;
        run    = 1'b1;
        while (!halted && cycles < halt_timeout) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        run = 1'b0;
        if (!halted) begin
            stop_with_failure($sformatf("timeout: core did not halt within %0d cycles",
                                        halt_timeout));
        end else begin
            check_value("trap", trap, exp_trap);
        end
    endtask

    // one line of the tests file
    task automatic run_line(input string line);
        int          fields;
        string       kind;
        string       name;
        logic [31:0] addr;
        logic [31:0] word;
        logic [31:0] rd_word;
        fields = $sscanf(line, "%s", kind);
        if (fields < 1 || kind.substr(0, 0) == "#") begin
            return;
        end
        if (kind == "test") begin
            fields = $sscanf(line, "%s %s", kind, name);
            $display("test %s", name);
            reset_dut();
            tests_run++;
        end else if (kind == "load") begin
            fields = $sscanf(line, "%s %h %h", kind, addr, word);
            if (fields != 3) begin
                stop_with_failure("malformed load line in tests file");
            end else begin
                host_write(addr[mem_aw-1:0], word);
            end
        end else if (kind == "run") begin
            fields = $sscanf(line, "%s %h", kind, word);
            if (fields != 2) begin
                stop_with_failure("malformed run line in tests file");
            end else begin
                run_to_halt(word[0]);
            end
        end else if (kind == "expect") begin
            fields = $sscanf(line, "%s %h %h", kind, addr, word);
            if (fields != 3) begin
                stop_with_failure("malformed expect line in tests file");
            end else begin
                host_read(addr[mem_aw-1:0], rd_word);
                check_value($sformatf("host_rd_data[%03h]", addr[mem_aw-1:0]), rd_word, word);
                checks_done++;
            end
        end else begin
            stop_with_failure($sformatf("unknown line kind '%s' in tests file", kind));
        end
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        int    fd;
        string line;
        clk          = 1'b0;
        rst_n        = 1'b0;
        run          = 1'b0;
        host_en      = 1'b0;
        host_wr_en   = 1'b0;
        host_addr    = '0;
        host_wr_data = '0;
        tests_run    = 0;
        checks_done  = 0;
        void'($urandom(rand_seed));
        fd = $fopen(tests_path, "r");
        if (fd == 0) begin
            stop_with_failure("could not open the tests file");
        end else begin
            while ($fgets(line, fd) != 0) begin
                run_line(line);
            end
            $fclose(fd);
            if (tests_run == 0 || checks_done == 0) begin
                stop_with_failure("tests file held no tests or no checks");
            end else begin
                $display("No errors");
                $finish;
            end
        end
    end

endmodule

// ==== src/rv_mini_top.sv ====
// rv_mini subsystem top

`timescale 1ns/10ps

module rv_mini_top (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           run,
    input  logic                           host_en,
    input  logic                           host_wr_en,
    input  logic [rv_mini_pkg::mem_aw-1:0] host_addr,
    input  logic [rv_mini_pkg::xlen-1:0]   host_wr_data,
    output logic [rv_mini_pkg::xlen-1:0]   host_rd_data,
    output logic                           halted,
    output logic                           trap
);

    import rv_mini_pkg::*;

    // core side
    logic              instr_req, instr_ack;
    logic [xlen-1:0]   instr_addr, instr_data;
    logic              data_req, data_wr_en, data_ack;
    logic [xlen-1:0]   data_addr, data_wr_data, data_rd_data;
    logic [3:0]        data_wr_mask;

    // memory side
    logic              mem_en, mem_wr_en;
    logic [mem_aw-1:0] mem_addr;
    logic [3:0]        mem_wr_mask;
    logic [xlen-1:0]   mem_wr_data, mem_rd_data;

    rv_mini_core u_core (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .instr_req   (instr_req),
        .instr_addr  (instr_addr),
        .instr_ack   (instr_ack),
        .instr_data  (instr_data),
        .data_req    (data_req),
        .data_wr_en  (data_wr_en),
        .data_addr   (data_addr),
        .data_wr_data(data_wr_data),
        .data_wr_mask(data_wr_mask),
        .data_ack    (data_ack),
        .data_rd_data(data_rd_data),
        .halted      (halted),
        .trap        (trap)
    );

    rv_mini_mem_arbiter u_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .instr_req   (instr_req),
        .instr_addr  (instr_addr),
        .instr_ack   (instr_ack),
        .instr_data  (instr_data),
        .data_req    (data_req),
        .data_wr_en  (data_wr_en),
        .data_addr   (data_addr),
        .data_wr_data(data_wr_data),
        .data_wr_mask(data_wr_mask),
        .data_ack    (data_ack),
        .data_rd_data(data_rd_data),
        .host_en     (host_en),
        .host_wr_en  (host_wr_en),
        .host_addr   (host_addr),
        .host_wr_data(host_wr_data),
        .host_rd_data(host_rd_data),
        .mem_en      (mem_en),
        .mem_wr_en   (mem_wr_en),
        .mem_addr    (mem_addr),
        .mem_wr_mask (mem_wr_mask),
        .mem_wr_data (mem_wr_data),
        .mem_rd_data (mem_rd_data)
    );

    rv_mini_sram u_sram (
        .clk    (clk),
        .en     (mem_en),
        .wr_en  (mem_wr_en),
        .addr   (mem_addr),
        .wr_mask(mem_wr_mask),
        .wr_data(mem_wr_data),
        .rd_data(mem_rd_data)
    );

endmodule

// ==== src/rv_mini_sram.sv ====
// rv_mini single-port memory

`timescale 1ns/10ps

module rv_mini_sram (
    input  logic                           clk,
    input  logic                           en,
    input  logic                           wr_en,
    input  logic [rv_mini_pkg::mem_aw-1:0] addr,
    input  logic [3:0]                     wr_mask,
    input  logic [rv_mini_pkg::xlen-1:0]   wr_data,
    output logic [rv_mini_pkg::xlen-1:0]   rd_data
);

    import rv_mini_pkg::*;

    logic [xlen-1:0] mem [mem_words];

    // ----------------------------------------
    // byte-masked write, registered read
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (en) begin
            if (wr_en) begin
                for (int b = 0; b < 4; b++) begin
                    if (wr_mask[b]) begin
                        mem[addr][8*b +: 8] <= wr_data[8*b +: 8];
                    end
                end
            end else begin
                // read data one cycle after the enable
                rd_data <= mem[addr];
            end
        end
    end

endmodule

// ==== src/rv_mini_mem_arbiter.sv ====
// rv_mini memory arbiter
// host, then data, then instruction fetch

`timescale 1ns/10ps

module rv_mini_mem_arbiter (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           run,
    input  logic                           instr_req,
    input  logic [rv_mini_pkg::xlen-1:0]   instr_addr,
    output logic                           instr_ack,
    output logic [rv_mini_pkg::xlen-1:0]   instr_data,
    input  logic                           data_req,
    input  logic                           data_wr_en,
    input  logic [rv_mini_pkg::xlen-1:0]   data_addr,
    input  logic [rv_mini_pkg::xlen-1:0]   data_wr_data,
    input  logic [3:0]                     data_wr_mask,
    output logic                           data_ack,
    output logic [rv_mini_pkg::xlen-1:0]   data_rd_data,
    input  logic                           host_en,
    input  logic                           host_wr_en,
    input  logic [rv_mini_pkg::mem_aw-1:0] host_addr,
    input  logic [rv_mini_pkg::xlen-1:0]   host_wr_data,
    output logic [rv_mini_pkg::xlen-1:0]   host_rd_data,
    output logic                           mem_en,
    output logic                           mem_wr_en,
    output logic [rv_mini_pkg::mem_aw-1:0] mem_addr,
    output logic [3:0]                     mem_wr_mask,
    output logic [rv_mini_pkg::xlen-1:0]   mem_wr_data,
    input  logic [rv_mini_pkg::xlen-1:0]   mem_rd_data
);

    import rv_mini_pkg::*;

    logic host_sel, data_sel, instr_sel;
    logic instr_gnt_q, data_gnt_q;
    logic busy;

    // no new core access while an ack is outstanding
    assign busy      = instr_gnt_q | data_gnt_q;
    assign host_sel  = host_en & ~run;
    assign data_sel  = data_req & ~busy & ~host_sel;
    assign instr_sel = instr_req & ~data_req & ~busy & ~host_sel;

    always_comb begin
        mem_en      = host_sel | data_sel | instr_sel;
        mem_wr_en   = 1'b0;
        mem_wr_mask = data_wr_mask;
        mem_wr_data = data_wr_data;
        // byte address to word address
        mem_addr    = instr_addr[mem_aw+1:2];
        if (host_sel) begin
            // host addresses are already word addresses
            mem_wr_en   = host_wr_en;
            mem_addr    = host_addr;
            mem_wr_mask = 4'hf;
            mem_wr_data = host_wr_data;
        end else if (data_sel) begin
            mem_wr_en = data_wr_en;
            mem_addr  = data_addr[mem_aw+1:2];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr_gnt_q <= 1'b0;
            data_gnt_q  <= 1'b0;
        end else begin
            instr_gnt_q <= instr_sel;
            data_gnt_q  <= data_sel;
        end
    end

    assign instr_ack    = instr_gnt_q;
    assign data_ack     = data_gnt_q;
    assign instr_data   = mem_rd_data;
    assign data_rd_data = mem_rd_data;
    assign host_rd_data = mem_rd_data;

    a_host_idle: assert property (@(posedge clk) disable iff (!rst_n)
        host_en |-> !run);
    a_one_ack: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({instr_ack, data_ack}));

endmodule

// ==== src/rv_mini_core.sv ====
// rv_mini multi-cycle core

`timescale 1ns/10ps

module rv_mini_core (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         run,
    output logic                         instr_req,
    output logic [rv_mini_pkg::xlen-1:0] instr_addr,
    input  logic                         instr_ack,
    input  logic [rv_mini_pkg::xlen-1:0] instr_data,
    output logic                         data_req,
    output logic                         data_wr_en,
    output logic [rv_mini_pkg::xlen-1:0] data_addr,
    output logic [rv_mini_pkg::xlen-1:0] data_wr_data,
    output logic [3:0]                   data_wr_mask,
    input  logic                         data_ack,
    input  logic [rv_mini_pkg::xlen-1:0] data_rd_data,
    output logic                         halted,
    output logic                         trap
);

    import rv_mini_pkg::*;

    core_state_t     state;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] instr_q;

    // instruction fields
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [xlen-1:0] imm_i, imm_s, imm_b, imm_u;
    logic [xlen-1:0] rs1_data, rs2_data;

    // decode results
    logic            wb_en;
    logic [xlen-1:0] wb_data;
    logic            is_load, is_store, is_ebreak, illegal;
    logic [xlen-1:0] next_pc;
    logic            rd_wr_en;
    logic [xlen-1:0] rd_data;

    assign opcode = instr_q[6:0];
    assign funct3 = instr_q[14:12];
    assign funct7 = instr_q[31:25];
    assign imm_i  = {{20{instr_q[31]}}, instr_q[31:20]};
    assign imm_s  = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
    assign imm_b  = {{19{instr_q[31]}}, instr_q[31], instr_q[7], instr_q[30:25],
                     instr_q[11:8], 1'b0};
    assign imm_u  = {instr_q[31:12], 12'b0};

    rv_mini_regfile u_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs1_addr(instr_q[19:15]),
        .rs2_addr(instr_q[24:20]),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .rd_wr_en(rd_wr_en),
        .rd_addr (instr_q[11:7]),
        .rd_data (rd_data)
    );

    // ----------------------------------------
    // decode and execute
    // ----------------------------------------
    always_comb begin
        wb_en     = 1'b0;
        wb_data   = rs1_data + rs2_data;
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_ebreak = 1'b0;
        illegal   = 1'b0;
        next_pc   = pc + 32'd4;
        case (opcode)
            opc_op: begin
                wb_en = 1'b1;
                if (funct3 != funct3_add_sub) illegal = 1'b1;
                else if (funct7 == funct7_sub) wb_data = rs1_data - rs2_data;
                else if (funct7 != funct7_add) illegal = 1'b1;
            end
            opc_op_imm: begin
                wb_en   = 1'b1;
                wb_data = rs1_data + imm_i;
                illegal = (funct3 != funct3_add_sub);
            end
            opc_lui: begin
                wb_en   = 1'b1;
                wb_data = imm_u;
            end
            opc_load: begin
                is_load = 1'b1;
                illegal = (funct3 != funct3_word);
            end
            opc_store: begin
                is_store = 1'b1;
                illegal  = (funct3 != funct3_word);
            end
            opc_branch: begin
                illegal = (funct3 != funct3_bne);
                if (rs1_data != rs2_data) next_pc = pc + imm_b;
            end
            opc_system: begin
                is_ebreak = (instr_q == instr_ebreak);
                illegal   = !is_ebreak;
            end
            default: illegal = 1'b1;
        endcase
    end

    // alu results write in execute and loads on the data ack
    assign rd_wr_en = (state == state_execute && wb_en && !illegal)
                   || (state == state_mem_wait && data_ack && is_load);
    assign rd_data  = (state == state_mem_wait) ? data_rd_data : wb_data;

    // ----------------------------------------
    // sequencer
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= state_reset;
            pc    <= '0;
            trap  <= 1'b0;
        end else begin
            case (state)
                state_reset: state <= state_fetch;
                // run only gates the start of a fetch
                state_fetch: if (run) state <= state_fetch_wait;
                state_fetch_wait: if (instr_ack) state <= state_execute;
                state_execute: begin
                    if (illegal) begin
                        trap  <= 1'b1;
                        state <= state_halt;
                    end else if (is_ebreak) begin
                        state <= state_halt;
                    end else begin
                        pc    <= next_pc;
                        state <= (is_load || is_store) ? state_mem : state_fetch;
                    end
                end
                state_mem: state <= state_mem_wait;
                state_mem_wait: if (data_ack) state <= state_fetch;
                default: state <= state_halt;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == state_fetch_wait && instr_ack) begin
            instr_q <= instr_data;
        end
    end

    assign instr_req    = (state == state_fetch && run) || state == state_fetch_wait;
    assign instr_addr   = pc;
    assign data_req     = (state == state_mem) || (state == state_mem_wait);
    assign data_wr_en   = data_req && is_store;
    assign data_addr    = rs1_data + (is_store ? imm_s : imm_i);
    assign data_wr_data = rs2_data;
    assign data_wr_mask = {4{data_wr_en}};
    assign halted       = (state == state_halt);

    // ----------------------------------------
    // checks
    // ----------------------------------------
    a_one_req: assert property (@(posedge clk) disable iff (!rst_n)
        !(instr_req && data_req));
    a_instr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        instr_req && !instr_ack |=> instr_req && $stable(instr_addr));
    a_data_hold: assert property (@(posedge clk) disable iff (!rst_n)
        data_req && !data_ack |=> data_req && $stable(data_addr));
    a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        state == state_halt |=> state == state_halt);

endmodule

// ==== src/rv_mini_regfile.sv ====
// rv_mini register file

`timescale 1ns/10ps

module rv_mini_regfile (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [4:0]                  rs1_addr,
    input  logic [4:0]                  rs2_addr,
    output logic [rv_mini_pkg::xlen-1:0] rs1_data,
    output logic [rv_mini_pkg::xlen-1:0] rs2_data,
    input  logic                        rd_wr_en,
    input  logic [4:0]                  rd_addr,
    input  logic [rv_mini_pkg::xlen-1:0] rd_data
);

    import rv_mini_pkg::*;

    // x0 has no storage
    logic [xlen-1:0] regs [1:31];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_wr_en && rd_addr != 5'd0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    // combinational reads with x0 tied to zero
    always_comb begin
        rs1_data = '0;
        rs2_data = '0;
        if (rs1_addr != 5'd0) begin
            rs1_data = regs[rs1_addr];
        end
        if (rs2_addr != 5'd0) begin
            rs2_data = regs[rs2_addr];
        end
    end

endmodule

// ==== src/rv_mini_pkg.sv ====
// rv_mini shared definitions
// widths, opcodes and core states

package rv_mini_pkg;

    // ----------------------------------------
    // sizes
    // ----------------------------------------
    localparam int xlen      = 32;
    localparam int mem_words = 1024;
    localparam int mem_aw    = $clog2(mem_words);

    // ----------------------------------------
    // rv32 major opcodes
    // ----------------------------------------
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_system = 7'b1110011;

    // funct fields of the supported subset
    localparam logic [2:0] funct3_add_sub = 3'b000;
    localparam logic [2:0] funct3_bne     = 3'b001;
    // lw and sw take whole words only
    localparam logic [2:0] funct3_word    = 3'b010;
    localparam logic [6:0] funct7_add     = 7'b0000000;
    localparam logic [6:0] funct7_sub     = 7'b0100000;

    // full encoding of ebreak
    localparam logic [xlen-1:0] instr_ebreak = 32'h0010_0073;

    // ----------------------------------------
    // core sequencer
    // ----------------------------------------
    typedef enum logic [2:0] {
        state_reset,
        state_fetch,
        state_fetch_wait,
        state_execute,
        state_mem,
        state_mem_wait,
        state_halt
    } core_state_t;

endpackage
